//--- src/dft_mem_pkg.sv
//----------------------------------------------------------------------
// shared types for the DFT memory controller; packets up to 7 x 256
// points, radices 2 to 5, at most six factor stages
//----------------------------------------------------------------------
package dft_mem_pkg;

	// array geometry
	localparam int num_banks   = 7;
	localparam int num_lanes   = 5;
	localparam int max_factors = 6;
	localparam int bank_depth  = 256;

	typedef logic signed [17:0] in_sample_t;
	typedef logic signed [29:0] sample_t;
	typedef logic [11:0]        addr_t;
	typedef logic [7:0]         bank_row_t;
	typedef logic [2:0]         bank_idx_t;
	typedef logic [2:0]         factor_t;
	typedef logic [2:0]         stage_t;
	typedef logic [num_lanes-1:0] lane_mask_t;

	typedef struct packed {
		sample_t re;
		sample_t im;
	} cplx_t;

	typedef addr_t [num_lanes-1:0] lane_addr_t;
	typedef cplx_t [num_lanes-1:0] lane_data_t;

	// num_factors counts the used entries of factors, from index 0
	typedef struct packed {
		addr_t                       points;
		stage_t                      num_factors;
		factor_t [max_factors-1:0]   factors;
	} dft_cfg_t;

	typedef struct packed {
		logic       valid;
		logic       sop;
		in_sample_t re;
		in_sample_t im;
	} stream_in_t;

	typedef struct packed {
		logic  valid;
		logic  sop;
		logic  eop;
		cplx_t data;
	} stream_out_t;

	//------------------------------------------------------------------
	// radix engine handshake
	//------------------------------------------------------------------
	typedef struct packed {
		logic       valid;
		factor_t    factor;
		stage_t     stage;
		lane_mask_t mask;
		lane_addr_t addr;
		lane_data_t data;
	} bfly_req_t;

	typedef struct packed {
		logic       valid;
		lane_mask_t mask;
		lane_addr_t addr;
		lane_data_t data;
	} bfly_rsp_t;

	typedef enum logic [2:0] {
		st_idle,
		st_sink,
		st_read,
		st_drain,
		st_source
	} mem_state_e;

endpackage

//--- src/bank_map.sv
//----------------------------------------------------------------------
// row is the quotient truncated to the bank row width
//----------------------------------------------------------------------
module bank_map
	import dft_mem_pkg::*;
(
	input  addr_t     addr,
	output bank_row_t row,
	output bank_idx_t bank
);

	logic [3:0] rem;
	addr_t      quot;

	// restoring division by 7, one bit per step from the msb
	always_comb
	begin
		rem  = '0;
		quot = '0;
		for (int i = $bits(addr_t) - 1; i >= 0; i--)
		begin
			rem = {rem[2:0], addr[i]};
			if (rem >= 4'd7)
			begin
				rem     = rem - 4'd7;
				quot[i] = 1'b1;
			end
		end
	end

	assign row  = quot[$bits(bank_row_t)-1:0];
	// remainder is always below 7 here
	assign bank = rem[2:0];

endmodule

//--- src/bank_array.sv
//----------------------------------------------------------------------
// lanes of one access must map to distinct banks (consecutive addresses)
// read data is valid one cycle after rd_addr and rd_mask
//----------------------------------------------------------------------
module bank_array
	import dft_mem_pkg::*;
#(
	parameter int bank_depth = dft_mem_pkg::bank_depth
)
(
	input  logic       clk,
	input  mem_state_e state,
	input  addr_t      sink_addr,
	input  cplx_t      sink_data,
	input  lane_mask_t rd_mask,
	input  lane_addr_t rd_addr,
	input  bfly_rsp_t  rsp,
	output lane_data_t rd_data
);

	bank_row_t  rd_row [num_lanes];
	bank_idx_t  rd_bank [num_lanes];
	bank_idx_t  rd_bank_r [num_lanes];
	addr_t      wr_addr [num_lanes];
	cplx_t      wr_data [num_lanes];
	bank_row_t  wr_row [num_lanes];
	bank_idx_t  wr_bank [num_lanes];
	lane_mask_t wr_act;
	logic       rsp_ok;

	logic [num_banks-1:0] bank_we;
	logic [num_banks-1:0] bank_re;
	bank_row_t            bank_wr_row [num_banks];
	bank_row_t            bank_rd_row [num_banks];
	cplx_t                bank_wr_data [num_banks];
	cplx_t                bank_q [num_banks];

	// engine results only land while a stage is running
	assign rsp_ok = rsp.valid && (state == st_read || state == st_drain);

	//------------------------------------------------------------------
	// write lane sources, sink shares lane 0
	//------------------------------------------------------------------
	always_comb
	begin
		for (int j = 0; j < num_lanes; j++)
		begin
			wr_addr[j] = rsp.addr[j];
			wr_data[j] = rsp.data[j];
			wr_act[j]  = rsp_ok & rsp.mask[j];
		end
		if (state == st_sink)
		begin
			wr_addr[0] = sink_addr;
			wr_data[0] = sink_data;
			wr_act[0]  = 1'b1;
		end
	end

	for (genvar j = 0; j < num_lanes; j++)
	begin : g_lane
		bank_map u_rd_map (
			.addr (rd_addr[j]),
			.row  (rd_row[j]),
			.bank (rd_bank[j])
		);

		bank_map u_wr_map (
			.addr (wr_addr[j]),
			.row  (wr_row[j]),
			.bank (wr_bank[j])
		);
	end

	//------------------------------------------------------------------
	// lane to bank crossbars
	//------------------------------------------------------------------
	always_comb
	begin
		for (int k = 0; k < num_banks; k++)
		begin
			bank_we[k]      = 1'b0;
			bank_wr_row[k]  = '0;
			bank_wr_data[k] = '0;
			bank_re[k]      = 1'b0;
			bank_rd_row[k]  = '0;
			for (int j = 0; j < num_lanes; j++)
			begin
				if (wr_act[j] && wr_bank[j] == bank_idx_t'(k))
				begin
					bank_we[k]      = 1'b1;
					bank_wr_row[k]  = wr_row[j];
					bank_wr_data[k] = wr_data[j];
				end
				if (rd_mask[j] && rd_bank[j] == bank_idx_t'(k))
				begin
					bank_re[k]     = 1'b1;
					bank_rd_row[k] = rd_row[j];
				end
			end
		end
	end

	for (genvar k = 0; k < num_banks; k++)
	begin : g_bank
		cplx_t mem [bank_depth];

		always_ff @(posedge clk)
		begin
			if (bank_we[k])
				mem[bank_wr_row[k]] <= bank_wr_data[k];
			if (bank_re[k])
				bank_q[k] <= mem[bank_rd_row[k]];
		end
	end

	// bank index follows the data through the RAM cycle
	always_ff @(posedge clk)
	begin
		for (int j = 0; j < num_lanes; j++)
			rd_bank_r[j] <= rd_bank[j];
	end

	always_comb
	begin
		for (int j = 0; j < num_lanes; j++)
			rd_data[j] = bank_q[rd_bank_r[j]];
	end

endmodule

//--- src/mem_sequencer.sv
//----------------------------------------------------------------------
// samples must arrive on consecutive cycles after sop; the point count
// must equal the product of the factors; a sop while busy is dropped
//----------------------------------------------------------------------
module mem_sequencer
	import dft_mem_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  stream_in_t stream_in,
	input  dft_cfg_t   cfg,
	input  logic       rsp_valid,
	output mem_state_e state,
	output lane_mask_t rd_mask,
	output lane_addr_t rd_addr,
	output addr_t      sink_addr,
	output logic       req_valid,
	output factor_t    req_factor,
	output stage_t     req_stage,
	output lane_mask_t req_mask,
	output lane_addr_t req_addr,
	output logic       out_valid,
	output logic       out_sop,
	output logic       out_eop
);

	mem_state_e state_q;
	dft_cfg_t   cfg_r;
	addr_t      sink_cnt;
	addr_t      base;
	addr_t      next_base;
	addr_t      iss_cnt;
	addr_t      rsp_cnt;
	addr_t      rsp_sum;
	stage_t     stage;
	factor_t    cur_factor;
	factor_t    step;
	lane_mask_t lane_mask;
	logic       sop_take;
	logic       issuing;
	logic       p1_read;
	logic       p1_src;
	logic       p1_sop;
	logic       p1_eop;

	assign sop_take   = stream_in.valid && stream_in.sop && state_q == st_idle;
	assign cur_factor = cfg_r.factors[stage];
	// source walks one point per cycle on lane 0
	assign step       = (state_q == st_source) ? factor_t'(1) : cur_factor;
	assign next_base  = base + addr_t'(step);
	assign rsp_sum    = rsp_cnt + addr_t'(rsp_valid);
	assign issuing    = state_q == st_read || state_q == st_source;

	// the sop sample is written in the same cycle it is accepted
	assign state      = sop_take ? st_sink : state_q;
	assign sink_addr  = sink_cnt;

	always_comb
	begin
		for (int j = 0; j < num_lanes; j++)
			lane_mask[j] = j < int'(step);
	end

	//------------------------------------------------------------------
	// FSM with sink, group and response counters
	//------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state_q  <= st_idle;
			sink_cnt <= '0;
			base     <= '0;
			iss_cnt  <= '0;
			rsp_cnt  <= '0;
			stage    <= '0;
		end
		else
		begin
			case (state_q)
				st_idle:
					if (sop_take)
					begin
						state_q  <= st_sink;
						sink_cnt <= addr_t'(1);
					end
				st_sink:
					if (stream_in.valid)
					begin
						sink_cnt <= sink_cnt + 1'b1;
						if (sink_cnt == cfg_r.points - 1'b1)
						begin
							state_q  <= st_read;
							sink_cnt <= '0;
							base     <= '0;
							iss_cnt  <= '0;
							rsp_cnt  <= '0;
							stage    <= '0;
						end
					end
				st_read:
				begin
					base    <= next_base;
					iss_cnt <= iss_cnt + 1'b1;
					rsp_cnt <= rsp_sum;
					if (next_base >= cfg_r.points)
						state_q <= st_drain;
				end
				st_drain:
				begin
					rsp_cnt <= rsp_sum;
					// last result written on this edge
					if (rsp_sum == iss_cnt)
					begin
						base    <= '0;
						iss_cnt <= '0;
						rsp_cnt <= '0;
						stage   <= stage + 1'b1;
						if (stage + 1'b1 == cfg_r.num_factors)
							state_q <= st_source;
						else
							state_q <= st_read;
					end
				end
				st_source:
				begin
					base <= next_base;
					if (next_base >= cfg_r.points)
					begin
						state_q <= st_idle;
						base    <= '0;
					end
				end
				default:
					state_q <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (sop_take)
			cfg_r <= cfg;
	end

	//------------------------------------------------------------------
	// lane registers and framing, aligned to the bank read
	//------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_mask   <= '0;
			p1_read   <= 1'b0;
			p1_src    <= 1'b0;
			p1_sop    <= 1'b0;
			p1_eop    <= 1'b0;
			req_valid <= 1'b0;
			out_valid <= 1'b0;
			out_sop   <= 1'b0;
			out_eop   <= 1'b0;
		end
		else
		begin
			rd_mask   <= issuing ? lane_mask : '0;
			p1_read   <= state_q == st_read;
			p1_src    <= state_q == st_source;
			p1_sop    <= state_q == st_source && base == '0;
			p1_eop    <= state_q == st_source && next_base >= cfg_r.points;
			req_valid <= p1_read;
			out_valid <= p1_src;
			out_sop   <= p1_sop;
			out_eop   <= p1_eop;
		end
	end

	always_ff @(posedge clk)
	begin
		for (int j = 0; j < num_lanes; j++)
			rd_addr[j] <= base + addr_t'(j);
		req_addr <= rd_addr;
		req_mask <= rd_mask;
	end

	// stage is stable until every response of the stage is back
	assign req_factor = cur_factor;
	assign req_stage  = stage;

endmodule

//--- src/dft_mem_top.sv
//----------------------------------------------------------------------
// engine must take every request; no back-pressure on any interface
//----------------------------------------------------------------------
module dft_mem_top
	import dft_mem_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  stream_in_t  stream_in,
	input  dft_cfg_t    cfg,
	input  bfly_rsp_t   bfly_rsp,
	output bfly_req_t   bfly_req,
	output stream_out_t stream_out
);

	mem_state_e state;
	lane_mask_t rd_mask;
	lane_addr_t rd_addr;
	addr_t      sink_addr;
	cplx_t      sink_data;
	lane_data_t rd_data;

	// input samples widened to the stored width
	assign sink_data.re = sample_t'(signed'(stream_in.re));
	assign sink_data.im = sample_t'(signed'(stream_in.im));

	mem_sequencer u_seq (
		.clk        (clk),
		.rst_n      (rst_n),
		.stream_in  (stream_in),
		.cfg        (cfg),
		.rsp_valid  (bfly_rsp.valid),
		.state      (state),
		.rd_mask    (rd_mask),
		.rd_addr    (rd_addr),
		.sink_addr  (sink_addr),
		.req_valid  (bfly_req.valid),
		.req_factor (bfly_req.factor),
		.req_stage  (bfly_req.stage),
		.req_mask   (bfly_req.mask),
		.req_addr   (bfly_req.addr),
		.out_valid  (stream_out.valid),
		.out_sop    (stream_out.sop),
		.out_eop    (stream_out.eop)
	);

	bank_array u_banks (
		.clk       (clk),
		.state     (state),
		.sink_addr (sink_addr),
		.sink_data (sink_data),
		.rd_mask   (rd_mask),
		.rd_addr   (rd_addr),
		.rsp       (bfly_rsp),
		.rd_data   (rd_data)
	);

	assign bfly_req.data   = rd_data;
	assign stream_out.data = rd_data[0];

endmodule

//--- verif/dft_mem_sva.sv
//----------------------------------------------------------------------
// output protocol checks, bound into every dft_mem_top instance
//----------------------------------------------------------------------
module dft_mem_sva
	import dft_mem_pkg::*;
(
	input logic        clk,
	input logic        rst_n,
	input bfly_req_t   bfly_req,
	input stream_out_t stream_out
);

	timeunit 1ns;
	timeprecision 1ps;

	// flops clear on the edge that samples reset
	a_reset_quiet: assert property (@(posedge clk)
		!rst_n |=> !stream_out.valid && !bfly_req.valid)
		else $error("output valid high after a reset cycle");

	a_sop_valid: assert property (@(posedge clk) disable iff (!rst_n)
		stream_out.sop |-> stream_out.valid)
		else $error("stream_out sop without valid");

	a_eop_gap: assert property (@(posedge clk) disable iff (!rst_n)
		stream_out.valid && stream_out.eop |=> !stream_out.valid)
		else $error("stream_out valid right after eop");

	// radix f uses lanes 0 to f-1
	a_req_mask: assert property (@(posedge clk) disable iff (!rst_n)
		bfly_req.valid |-> bfly_req.mask == lane_mask_t'((1 << bfly_req.factor) - 1))
		else $error("request mask does not match its factor");

endmodule

bind dft_mem_top dft_mem_sva u_sva (
	.clk        (clk),
	.rst_n      (rst_n),
	.bfly_req   (bfly_req),
	.stream_out (stream_out)
);

//--- verif/dft_mem_tb.sv
//----------------------------------------------------------------------
// table rows must be products of radices 2 to 5; engine latency 1 to 4
//----------------------------------------------------------------------
module dft_mem_tb
	import dft_mem_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct {
		dft_cfg_t cfg;
		int       offset;
	} row_t;

	localparam int num_rows = 5;

	logic        clk = 1'b0;
	logic        rst_n;
	stream_in_t  stream_in;
	dft_cfg_t    cfg;
	bfly_rsp_t   bfly_rsp;
	bfly_req_t   bfly_req;
	stream_out_t stream_out;

	row_t      table_rows [num_rows];
	dft_cfg_t  cur_cfg;
	cplx_t     ref_mem [4096];
	cplx_t     in_mem [4096];
	int        due_q [$];
	bfly_rsp_t rsp_q [$];
	int        exp_stage;
	int        grp;
	int        cyc = 0;
	int        err_count = 0;
	int        check_count = 0;

	dft_mem_top DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.stream_in  (stream_in),
		.cfg        (cfg),
		.bfly_rsp   (bfly_rsp),
		.bfly_req   (bfly_req),
		.stream_out (stream_out)
	);

	always #50 clk = ~clk;

	//------------------------------------------------------------------
	// compare tasks
	//------------------------------------------------------------------
	task automatic check_cplx(string name, cplx_t got, cplx_t exp);
		check_count++;
		if (got !== exp)
		begin
			err_count++;
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(string name, addr_t got, addr_t exp);
		check_count++;
		if (got !== exp)
		begin
			err_count++;
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_factor(string name, factor_t got, factor_t exp);
		check_count++;
		if (got !== exp)
		begin
			err_count++;
			$display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_stage(string name, stage_t got, stage_t exp);
		check_count++;
		if (got !== exp)
		begin
			err_count++;
			$display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_mask(string name, lane_mask_t got, lane_mask_t exp);
		check_count++;
		if (got !== exp)
		begin
			err_count++;
			$display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		check_count++;
		if (got !== exp)
		begin
			err_count++;
			$display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	function automatic lane_mask_t low_lanes(factor_t f);
		lane_mask_t m;
		m = '0;
		for (int j = 0; j < int'(f); j++)
			m[j] = 1'b1;
		return m;
	endfunction

	function automatic row_t make_row(int points, int n, int offset, int f [max_factors]);
		row_t row;
		row.cfg.points      = addr_t'(points);
		row.cfg.num_factors = stage_t'(n);
		for (int i = 0; i < max_factors; i++)
			row.cfg.factors[i] = factor_t'(f[i]);
		row.offset = offset;
		return row;
	endfunction

	// group g of a stage reads g*f .. g*f+f-1 and holds the last stored values
	task automatic check_request();
		factor_t f;
		addr_t   a;
		if (exp_stage >= int'(cur_cfg.num_factors))
		begin
			err_count++;
			$display("Request at %0t arrived after the last stage of the packet", $time);
			return;
		end
		f = cur_cfg.factors[exp_stage];
		check_stage("bfly_req.stage", bfly_req.stage, stage_t'(exp_stage));
		check_factor("bfly_req.factor", bfly_req.factor, f);
		check_mask("bfly_req.mask", bfly_req.mask, low_lanes(f));
		for (int j = 0; j < int'(f); j++)
		begin
			a = addr_t'(grp * int'(f) + j);
			check_addr($sformatf("bfly_req.addr[%0d]", j), bfly_req.addr[j], a);
			check_cplx($sformatf("bfly_req.data[%0d]", j), bfly_req.data[j], ref_mem[a]);
			ref_mem[a].re = ref_mem[a].re + sample_t'(exp_stage + 1);
		end
		grp++;
		if (grp * int'(f) >= int'(cur_cfg.points))
		begin
			grp = 0;
			exp_stage++;
		end
	endtask

	//------------------------------------------------------------------
	// radix engine model with in-order responses
	//------------------------------------------------------------------
	always @(posedge clk)
	begin
		bfly_rsp_t rsp;
		int        due;
		cyc = cyc + 1;
		if (!rst_n)
		begin
			due_q.delete();
			rsp_q.delete();
			bfly_rsp <= '0;
		end
		else
		begin
			if (bfly_req.valid)
			begin
				check_request();
				rsp.valid = 1'b1;
				rsp.mask  = bfly_req.mask;
				rsp.addr  = bfly_req.addr;
				rsp.data  = bfly_req.data;
				for (int j = 0; j < num_lanes; j++)
					rsp.data[j].re = bfly_req.data[j].re + sample_t'(bfly_req.stage) + 1;
				due = cyc + 1 + int'($urandom % 4);
				// responses leave one per cycle in request order
				if (due_q.size() > 0 && due <= due_q[$])
					due = due_q[$] + 1;
				due_q.push_back(due);
				rsp_q.push_back(rsp);
			end
			if (due_q.size() > 0 && due_q[0] == cyc)
			begin
				void'(due_q.pop_front());
				bfly_rsp <= rsp_q.pop_front();
			end
			else
				bfly_rsp.valid <= 1'b0;
		end
	end

	task automatic run_watchdog();
		int limit;
		limit = 5 + 4;
		for (int r = 0; r < num_rows; r++)
			limit += int'(table_rows[r].cfg.points) * (int'(table_rows[r].cfg.num_factors) + 3) * 8;
		repeat (limit) @(posedge clk);
		$display("Timeout: the run did not end within %0d clock cycles", limit);
		$display("Errors found");
		$finish;
	endtask

	//------------------------------------------------------------------
	// one packet with sink, stray sop while busy and the output check
	//------------------------------------------------------------------
	task automatic run_packet(input row_t row);
		in_sample_t re;
		in_sample_t im;
		cplx_t      exp;
		int         got;
		bit         done;
		cur_cfg   = row.cfg;
		exp_stage = 0;
		grp       = 0;
		for (int n = 0; n < int'(row.cfg.points); n++)
		begin
			re = in_sample_t'($urandom);
			im = in_sample_t'($urandom);
			in_mem[n].re = sample_t'(re);
			in_mem[n].im = sample_t'(im);
			ref_mem[n]   = in_mem[n];
			@(posedge clk);
			stream_in <= '{valid: 1'b1, sop: n == 0, re: re, im: im};
			cfg       <= row.cfg;
		end
		// sample past the point count
		@(posedge clk);
		stream_in <= '{valid: 1'b1, sop: 1'b0, re: in_sample_t'($urandom), im: '0};
		@(posedge clk);
		stream_in <= '0;
		@(posedge clk);
		stream_in <= '{valid: 1'b1, sop: 1'b1, re: '1, im: '1};
		cfg       <= ~row.cfg;
		@(posedge clk);
		stream_in <= '0;
		got  = 0;
		done = 1'b0;
		while (!done)
		begin
			@(posedge clk);
			// no gaps once the first point is out
			if (got > 0)
				check_flag("stream_out.valid", stream_out.valid, 1'b1);
			if (stream_out.valid)
			begin
				check_flag("stream_out.sop", stream_out.sop, got == 0);
				check_flag("stream_out.eop", stream_out.eop, got == int'(row.cfg.points) - 1);
				exp    = in_mem[got];
				exp.re = exp.re + sample_t'(row.offset);
				check_cplx("stream_out.data", stream_out.data, exp);
				got++;
				done = stream_out.eop || got >= int'(row.cfg.points);
			end
		end
		if (got != int'(row.cfg.points) || exp_stage != int'(row.cfg.num_factors))
		begin
			err_count++;
			$display("Packet of %0d points ended after %0d points and %0d stages",
				row.cfg.points, got, exp_stage);
		end
		repeat (4)
		begin
			@(posedge clk);
			check_flag("stream_out.valid", stream_out.valid, 1'b0);
		end
	endtask

	initial
	begin
		void'($urandom(32'h7980_0d46));
		rst_n     = 1'b0;
		stream_in = '0;
		cfg       = '0;
		bfly_rsp  = '0;
		// points, factor count, sum of (stage + 1), radices
		table_rows[0] = make_row(60, 3, 6, '{3, 4, 5, 0, 0, 0});
		table_rows[1] = make_row(30, 3, 6, '{2, 3, 5, 0, 0, 0});
		table_rows[2] = make_row(8, 3, 6, '{2, 2, 2, 0, 0, 0});
		// 25 = 5*5 stands in for 35 = 5*7 as radix 7 is unsupported
		table_rows[3] = make_row(25, 2, 3, '{5, 5, 0, 0, 0, 0});
		table_rows[4] = make_row(64, 6, 21, '{2, 2, 2, 2, 2, 2});
		fork
			run_watchdog();
		join_none
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		// quiet outputs before the first sop
		repeat (4)
		begin
			@(posedge clk);
			check_flag("stream_out.valid", stream_out.valid, 1'b0);
			check_flag("bfly_req.valid", bfly_req.valid, 1'b0);
		end
		for (int r = 0; r < num_rows; r++)
			run_packet(table_rows[r]);
		$display("%0d checks, %0d errors", check_count, err_count);
		if (err_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- list.f
src/dft_mem_pkg.sv
src/bank_map.sv
src/bank_array.sv
src/mem_sequencer.sv
src/dft_mem_top.sv
verif/dft_mem_sva.sv
verif/dft_mem_tb.sv

//--- Bender.yml
package:
  name: dft_mem

sources:
  - src/dft_mem_pkg.sv
  - src/bank_map.sv
  - src/bank_array.sv
  - src/mem_sequencer.sv
  - src/dft_mem_top.sv
  - target: test
    files:
      - verif/dft_mem_sva.sv
      - verif/dft_mem_tb.sv
